// File: sim.f
+incdir+dv
verilog/cpuPkg.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/cpuTop.sv
dv/cpuTb.sv

// File: dv/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state, stepped once per fetch
cpuPkg::wordT mPc = '0;
cpuPkg::wordT mRegs [0:cpuPkg::RegCount-1] = '{default: '0};
cpuPkg::wordT modelMem [0:255];
int           retired = 0;

// Bus behavior expected from the instruction just fetched
int           expLatency;
logic         expRead;
logic         expWrite;
cpuPkg::wordT expAddr;
cpuPkg::wordT expData;

function automatic cpuPkg::wordT regValue(input cpuPkg::regIdxT idx);
    return (idx == '0) ? '0 : mRegs[idx];
endfunction

task automatic stepModel(input cpuPkg::wordT instr);
    cpuPkg::opcodeT op;
    cpuPkg::regIdxT ra;
    cpuPkg::wordT   vA;
    cpuPkg::wordT   vB;
    cpuPkg::wordT   vC;
    cpuPkg::wordT   result;
    cpuPkg::wordT   pcPlus;
    cpuPkg::wordT   byteOff;
    cpuPkg::wordT   jumpOff;
    logic           writeBack;
    op = cpuPkg::opcodeT'(instr[15:12]);
    ra = instr[11:8];
    vA = regValue(ra);
    vB = regValue(instr[7:4]);
    vC = regValue(instr[3:0]);
    pcPlus = mPc + cpuPkg::wordT'(cpuPkg::PcStep);
    // Branch and jump fields count words, not bytes
    byteOff = {{7{instr[7]}}, instr[7:0], 1'b0};
    jumpOff = {{3{instr[11]}}, instr[11:0], 1'b0};
    result = '0;
    writeBack = 1'b1;
    expRead = 1'b0;
    expWrite = 1'b0;
    expAddr = vB + vC;
    expData = vA;
    expLatency = 4;
    mPc = pcPlus;
    case (op)
        cpuPkg::OpAdd:  result = vB + vC;
        cpuPkg::OpSub:  result = vB - vC;
        cpuPkg::OpSll:  result = vB << vC[3:0];
        cpuPkg::OpSrl:  result = vB >> vC[3:0];
        cpuPkg::OpSra:  result = cpuPkg::wordT'($signed(vB) >>> vC[3:0]);
        cpuPkg::OpNand: result = ~(vB & vC);
        cpuPkg::OpOr:   result = vB | vC;
        cpuPkg::OpAddi: result = vA + {{8{instr[7]}}, instr[7:0]};
        cpuPkg::OpOri:  result = vA | {8'h00, instr[7:0]};
        cpuPkg::OpLw: begin
            result = modelMem[expAddr[8:1]];
            expRead = 1'b1;
            expLatency = 5;
        end
        cpuPkg::OpSw: begin
            modelMem[expAddr[8:1]] = vA;
            expWrite = 1'b1;
            writeBack = 1'b0;
        end
        cpuPkg::OpBeqz, cpuPkg::OpBnez, cpuPkg::OpJmp: begin
            writeBack = 1'b0;
            expLatency = 3;
            if (op == cpuPkg::OpJmp) begin
                mPc = pcPlus + jumpOff;
            end else if ((vA == '0) == (op == cpuPkg::OpBeqz)) begin
                mPc = pcPlus + byteOff;
            end
        end
        // Unused opcodes retire right after decode
        default: begin
            writeBack = 1'b0;
            expLatency = 2;
        end
    endcase
    if (writeBack && ra != '0) begin
        mRegs[ra] = result;
    end
    retired++;
endtask

`endif

// File: dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    logic         clk;
    logic         rst;
    cpuPkg::wordT instrAddr;
    logic         instrRead;
    cpuPkg::wordT instrData;
    cpuPkg::wordT dataAddr;
    cpuPkg::wordT dataWrData;
    logic         dataRead;
    logic         dataWrite;
    cpuPkg::wordT dataRdData;

    cpuPkg::wordT instrMem [0:255];
    cpuPkg::wordT dataMem [0:255];
    integer       seed;
    int           progLen = 0;
    logic         ready = 1'b0;
    cpuPkg::wordT haltPc;

    // Directed words, opcode nibble first, then rA rB rC
    cpuPkg::wordT headWords [0:14] = '{
        // Immediates, then every ALU operation
        16'h7105, 16'h72FD, 16'h8380,
        16'h0412, 16'h1512, 16'h2631, 16'h3721, 16'h4821, 16'h5912, 16'h6A31,
        // ADDI into r0, store and load back, load of a preset word, store of r0
        16'h707F, 16'hA413, 16'h9B13, 16'h9C00, 16'hA011
    };
    cpuPkg::wordT tailWords [0:11] = '{
        // Taken BEQZ, untaken BEQZ, taken BNEZ, untaken BNEZ, two no-ops
        16'hB001, 16'h7101, 16'hB101, 16'hC101, 16'h7101, 16'hC001,
        16'hE123, 16'hF000,
        // Forward jump, store reached from the backward jump, exit, backward jump
        16'hD002, 16'hA100, 16'hD001, 16'hDFFD
    };

    // Monitor bookkeeping
    logic fetchSeen = 1'b0;
    logic done = 1'b0;
    int   cycles = 0;
    int   readsSeen = 0;
    int   writesSeen = 0;
    int   haltFetches = 0;
    int   mismatchCount = 0;
    int   failureCount = 0;

    // Data bus strobes captured mid-cycle
    logic         memRead = 1'b0;
    logic         memWrite = 1'b0;
    cpuPkg::wordT memAddr;
    cpuPkg::wordT memData;

    `include "isaModel.svh"

    cpuTop UUT (
        .clk        (clk),
        .rst        (rst),
        .instrAddr  (instrAddr),
        .instrRead  (instrRead),
        .instrData  (instrData),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataRdData (dataRdData)
    );

    assign instrData = instrMem[instrAddr[8:1]];

    always #20 clk = ~clk;

    task automatic reportMismatch(input string name, input int got, input int exp);
        mismatchCount++;
        $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic reportFailure(input string what);
        failureCount++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic placeWord(input cpuPkg::wordT word);
        instrMem[progLen] = word;
        progLen++;
    endtask

    // SW rX, r0, r0 for each register in the range
    task automatic storeRegs(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            placeWord({4'hA, r[3:0], 8'h00});
        end
    endtask

    task automatic buildProgram();
        int             pick;
        logic [11:0]    fields;
        cpuPkg::opcodeT op;
        for (int i = 0; i < 15; i++) begin
            placeWord(headWords[i]);
        end
        storeRegs(1, 12);
        for (int i = 0; i < 12; i++) begin
            placeWord(tailWords[i]);
        end
        // Random ALU, immediate and store instructions
        for (int i = 0; i < 20; i++) begin
            pick = $unsigned($random(seed)) % 10;
            fields = $random(seed);
            op = (pick == 9) ? cpuPkg::OpSw : cpuPkg::opcodeT'(pick[3:0]);
            placeWord({op, fields});
        end
        storeRegs(1, cpuPkg::RegCount - 1);
        haltPc = progLen * cpuPkg::PcStep;
        placeWord(16'hDFFF);
    endtask

    always @(negedge clk) begin
        if (!fetchSeen) begin
            assert (dataRead === 1'b0 && dataWrite === 1'b0)
                else reportFailure("memory strobe before the first fetch");
        end
        if (rst) begin
            fetchSeen = 1'b0;
            haltFetches = 0;
        end else begin
            cycles++;
            if (fetchSeen && dataRead) begin
                readsSeen++;
                assert (expRead) else reportFailure("dataRead pulse outside a load");
                assert (dataAddr == expAddr) else reportMismatch("dataAddr", dataAddr, expAddr);
            end
            if (fetchSeen && dataWrite) begin
                writesSeen++;
                assert (expWrite) else reportFailure("dataWrite pulse outside a store");
                assert (dataAddr == expAddr) else reportMismatch("dataAddr", dataAddr, expAddr);
                assert (dataWrData == expData)
                    else reportMismatch("dataWrData", dataWrData, expData);
            end
            if (instrRead) begin
                if (fetchSeen) begin
                    assert (cycles == expLatency)
                        else reportMismatch("fetch interval", cycles, expLatency);
                    assert (readsSeen == expRead)
                        else reportMismatch("dataRead cycles", readsSeen, expRead);
                    assert (writesSeen == expWrite)
                        else reportMismatch("dataWrite cycles", writesSeen, expWrite);
                end
                assert (instrAddr == mPc) else reportMismatch("instrAddr", instrAddr, mPc);
                if (mPc == haltPc) begin
                    haltFetches++;
                end
                if (haltFetches == 2) begin
                    done = 1'b1;
                end else begin
                    stepModel(instrMem[mPc[8:1]]);
                end
                cycles = 0;
                readsSeen = 0;
                writesSeen = 0;
                fetchSeen = 1'b1;
            end
        end
    end

    // Data memory, read data one cycle after the strobe
    always @(negedge clk) begin
        memRead = dataRead;
        memWrite = dataWrite;
        memAddr = dataAddr;
        memData = dataWrData;
    end

    always @(posedge clk) begin
        #1;
        if (memRead === 1'b1) begin
            dataRdData = dataMem[memAddr[8:1]];
        end
        if (memWrite === 1'b1) begin
            dataMem[memAddr[8:1]] = memData;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dataRdData = '0;
        seed = 76;
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = {8'hF0, i[7:0]};
            dataMem[i] = cpuPkg::wordT'($random(seed));
            modelMem[i] = dataMem[i];
        end
        buildProgram();
        ready = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        wait (done);
        $display("Retired %0d instructions, %0d mismatches, %0d other errors",
                 retired, mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Worst case five cycles per word, plus reset and margin
    initial begin
        wait (ready);
        #((progLen * 5 + 40) * 40);
        $display("Timeout: the program never reached its final jump");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic         clk,
    input  logic         rst,
    output cpuPkg::wordT instrAddr,
    output logic         instrRead,
    input  cpuPkg::wordT instrData,
    output cpuPkg::wordT dataAddr,
    output cpuPkg::wordT dataWrData,
    output logic         dataRead,
    output logic         dataWrite,
    input  cpuPkg::wordT dataRdData
);

    cpuPkg::opcodeT  opcode;
    logic            irWrite;
    logic            pcWrite;
    logic            pcWriteCond;
    logic            branchNe;
    logic            regWrite;
    logic            memToReg;
    cpuPkg::aluSrcAT aluSrcA;
    cpuPkg::aluSrcBT aluSrcB;
    cpuPkg::aluOpT   aluOp;

    // Memory strobes leave straight from the FSM
    controlUnit ctrl (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .instrRead   (instrRead),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .branchNe    (branchNe),
        .regWrite    (regWrite),
        .memToReg    (memToReg),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp)
    );

    datapath dp (
        .clk         (clk),
        .rst         (rst),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .branchNe    (branchNe),
        .regWrite    (regWrite),
        .memToReg    (memToReg),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .instrData   (instrData),
        .dataRdData  (dataRdData),
        .opcode      (opcode),
        .instrAddr   (instrAddr),
        .dataAddr    (dataAddr),
        .dataWrData  (dataWrData)
    );

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic            clk,
    input  logic            rst,
    input  logic            irWrite,
    input  logic            pcWrite,
    input  logic            pcWriteCond,
    input  logic            branchNe,
    input  logic            regWrite,
    input  logic            memToReg,
    input  cpuPkg::aluSrcAT aluSrcA,
    input  cpuPkg::aluSrcBT aluSrcB,
    input  cpuPkg::aluOpT   aluOp,
    input  cpuPkg::wordT    instrData,
    input  cpuPkg::wordT    dataRdData,
    output cpuPkg::opcodeT  opcode,
    output cpuPkg::wordT    instrAddr,
    output cpuPkg::wordT    dataAddr,
    output cpuPkg::wordT    dataWrData
);

    cpuPkg::wordT pc;
    cpuPkg::wordT ir;
    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT opC;
    cpuPkg::wordT aluOut;

    cpuPkg::wordT rfDataB;
    cpuPkg::wordT rfDataC;
    cpuPkg::wordT rfDataA;
    cpuPkg::wordT writeData;

    cpuPkg::wordT aluA;
    cpuPkg::wordT aluB;
    cpuPkg::wordT aluResult;
    logic         aluZero;

    cpuPkg::wordT immByte;
    cpuPkg::wordT branchOff;
    cpuPkg::wordT jumpOff;
    cpuPkg::wordT pcNext;
    logic         pcLoad;

    cpuPkg::regIdxT fieldA;
    cpuPkg::regIdxT fieldB;
    cpuPkg::regIdxT fieldC;

    // Instruction fields, opcode rA rB rC from the top
    assign opcode = cpuPkg::opcodeT'(ir[15:12]);
    assign fieldA = ir[11:8];
    assign fieldB = ir[7:4];
    assign fieldC = ir[3:0];

    // ORI zero-extends its byte, ADDI sign-extends
    assign immByte = (opcode == cpuPkg::OpOri)
                   ? {{(cpuPkg::DataWidth-8){1'b0}}, ir[7:0]}
                   : {{(cpuPkg::DataWidth-8){ir[7]}}, ir[7:0]};

    // Word offsets doubled to bytes
    assign branchOff = {{(cpuPkg::DataWidth-9){ir[7]}}, ir[7:0], 1'b0};
    assign jumpOff = {{(cpuPkg::DataWidth-13){ir[11]}}, ir[11:0], 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (irWrite) begin
            ir <= instrData;
        end
    end

    // Operand latches follow the IR fields and are settled from Decode on
    always_ff @(posedge clk) begin
        opA <= rfDataB;
        opB <= rfDataC;
        opC <= rfDataA;
        aluOut <= aluResult;
    end

    registerFile regFile (
        .clk       (clk),
        .readIdxB  (fieldB),
        .readIdxC  (fieldC),
        .readIdxA  (fieldA),
        .readDataB (rfDataB),
        .readDataC (rfDataC),
        .readDataA (rfDataA),
        .writeEn   (regWrite),
        .writeIdx  (fieldA),
        .writeData (writeData)
    );

    assign writeData = memToReg ? dataRdData : aluOut;

    always_comb begin
        case (aluSrcA)
            cpuPkg::SrcARegB: aluA = opA;
            cpuPkg::SrcARegA: aluA = opC;
            default:          aluA = pc;
        endcase
    end

    always_comb begin
        case (aluSrcB)
            cpuPkg::SrcBRegC:      aluB = opB;
            cpuPkg::SrcBTwo:       aluB = cpuPkg::wordT'(cpuPkg::PcStep);
            cpuPkg::SrcBImmByte:   aluB = immByte;
            cpuPkg::SrcBBranchOff: aluB = branchOff;
            cpuPkg::SrcBJumpOff:   aluB = jumpOff;
            default:               aluB = '0;
        endcase
    end

    alu aluUnit (
        .a      (aluA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // Branch taken when the zero flag disagrees with branchNe
    assign pcLoad = pcWrite | (pcWriteCond & (aluZero != branchNe));

    // Fetch takes PC + 2 from the ALU, Branch the target saved in Decode
    assign pcNext = irWrite ? aluResult : aluOut;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= pcNext;
        end
    end

    assign instrAddr = pc;
    assign dataAddr = aluOut;
    assign dataWrData = opC;

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::opcodeT  opcode,
    output logic            instrRead,
    output logic            irWrite,
    output logic            pcWrite,
    output logic            pcWriteCond,
    output logic            branchNe,
    output logic            regWrite,
    output logic            memToReg,
    output logic            dataRead,
    output logic            dataWrite,
    output cpuPkg::aluSrcAT aluSrcA,
    output cpuPkg::aluSrcBT aluSrcB,
    output cpuPkg::aluOpT   aluOp
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpuPkg::StFetch;
        end else begin
            state <= nextState;
        end
    end

    // Next state per instruction class
    always_comb begin
        nextState = cpuPkg::StFetch;
        case (state)
            cpuPkg::StFetch: nextState = cpuPkg::StDecode;
            cpuPkg::StDecode: begin
                case (opcode)
                    cpuPkg::OpBeqz, cpuPkg::OpBnez, cpuPkg::OpJmp:
                        nextState = cpuPkg::StBranch;
                    cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpSll, cpuPkg::OpSrl,
                    cpuPkg::OpSra, cpuPkg::OpNand, cpuPkg::OpOr, cpuPkg::OpAddi,
                    cpuPkg::OpOri, cpuPkg::OpLw, cpuPkg::OpSw:
                        nextState = cpuPkg::StExecute;
                    // Unused opcodes retire here
                    default: nextState = cpuPkg::StFetch;
                endcase
            end
            cpuPkg::StExecute: begin
                if (opcode == cpuPkg::OpLw || opcode == cpuPkg::OpSw) begin
                    nextState = cpuPkg::StMemAccess;
                end else begin
                    nextState = cpuPkg::StWriteBack;
                end
            end
            cpuPkg::StMemAccess: begin
                // Stores are done once the write strobe has gone out
                if (opcode == cpuPkg::OpLw) begin
                    nextState = cpuPkg::StWriteBack;
                end else begin
                    nextState = cpuPkg::StFetch;
                end
            end
            default: nextState = cpuPkg::StFetch;
        endcase
    end

    // One control word per state and opcode
    always_comb begin
        instrRead = 1'b0;
        irWrite = 1'b0;
        pcWrite = 1'b0;
        pcWriteCond = 1'b0;
        branchNe = 1'b0;
        regWrite = 1'b0;
        memToReg = 1'b0;
        dataRead = 1'b0;
        dataWrite = 1'b0;
        aluSrcA = cpuPkg::SrcAPc;
        aluSrcB = cpuPkg::SrcBZero;
        aluOp = cpuPkg::AluAdd;
        case (state)
            cpuPkg::StFetch: begin
                // PC + 2 straight from the ALU into the PC
                instrRead = 1'b1;
                irWrite = 1'b1;
                pcWrite = 1'b1;
                aluSrcB = cpuPkg::SrcBTwo;
            end
            cpuPkg::StDecode: begin
                // Speculative target into the ALU result register
                aluSrcB = (opcode == cpuPkg::OpJmp) ? cpuPkg::SrcBJumpOff
                                                    : cpuPkg::SrcBBranchOff;
            end
            cpuPkg::StExecute: begin
                aluSrcA = cpuPkg::SrcARegB;
                aluSrcB = cpuPkg::SrcBRegC;
                case (opcode)
                    cpuPkg::OpSub:  aluOp = cpuPkg::AluSub;
                    cpuPkg::OpSll:  aluOp = cpuPkg::AluSll;
                    cpuPkg::OpSrl:  aluOp = cpuPkg::AluSrl;
                    cpuPkg::OpSra:  aluOp = cpuPkg::AluSra;
                    cpuPkg::OpNand: aluOp = cpuPkg::AluNand;
                    cpuPkg::OpOr:   aluOp = cpuPkg::AluOr;
                    cpuPkg::OpAddi: begin
                        aluSrcA = cpuPkg::SrcARegA;
                        aluSrcB = cpuPkg::SrcBImmByte;
                    end
                    cpuPkg::OpOri: begin
                        aluSrcA = cpuPkg::SrcARegA;
                        aluSrcB = cpuPkg::SrcBImmByte;
                        aluOp = cpuPkg::AluOr;
                    end
                    // ADD, LW and SW all add rB and rC
                    default: aluOp = cpuPkg::AluAdd;
                endcase
            end
            cpuPkg::StMemAccess: begin
                dataRead = (opcode == cpuPkg::OpLw);
                dataWrite = (opcode == cpuPkg::OpSw);
            end
            cpuPkg::StWriteBack: begin
                regWrite = 1'b1;
                memToReg = (opcode == cpuPkg::OpLw);
            end
            cpuPkg::StBranch: begin
                // rA OR 0 drives the zero flag
                aluSrcA = cpuPkg::SrcARegA;
                aluOp = cpuPkg::AluOr;
                pcWrite = (opcode == cpuPkg::OpJmp);
                pcWriteCond = (opcode != cpuPkg::OpJmp);
                branchNe = (opcode == cpuPkg::OpBnez);
            end
            default: begin
                aluOp = cpuPkg::AluAdd;
            end
        endcase
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic           clk,
    input  cpuPkg::regIdxT readIdxB,
    input  cpuPkg::regIdxT readIdxC,
    input  cpuPkg::regIdxT readIdxA,
    output cpuPkg::wordT   readDataB,
    output cpuPkg::wordT   readDataC,
    output cpuPkg::wordT   readDataA,
    input  logic           writeEn,
    input  cpuPkg::regIdxT writeIdx,
    input  cpuPkg::wordT   writeData
);

    // r1 to r15, power-up contents all zero
    cpuPkg::wordT regs [1:cpuPkg::RegCount-1] = '{default: '0};

    // r0 has no storage and always reads zero
    assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];
    assign readDataC = (readIdxC == '0) ? '0 : regs[readIdxC];
    assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];

    always_ff @(posedge clk) begin
        if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpT op,
    output cpuPkg::wordT  result,
    output logic          zero
);

    logic [$clog2(cpuPkg::DataWidth)-1:0] shamt;

    // Only the low bits of b count for shifts
    assign shamt = b[$clog2(cpuPkg::DataWidth)-1:0];

    always_comb begin
        case (op)
            cpuPkg::AluAdd:  result = a + b;
            cpuPkg::AluSub:  result = a - b;
            cpuPkg::AluSll:  result = a << shamt;
            cpuPkg::AluSrl:  result = a >> shamt;
            // Arithmetic, sign bit fills from the left
            cpuPkg::AluSra:  result = cpuPkg::wordT'($signed(a) >>> shamt);
            cpuPkg::AluNand: result = ~(a & b);
            cpuPkg::AluOr:   result = a | b;
            default:         result = '0;
        endcase
    end

    // Used by BEQZ and BNEZ with rA on the a input
    assign zero = (result == '0);

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

    // Machine word and register file size
    localparam int DataWidth = 16;
    localparam int RegCount = 16;

    // Byte addressing, one word per fetch
    localparam int PcStep = 2;

    typedef logic [DataWidth-1:0] wordT;
    typedef logic [$clog2(RegCount)-1:0] regIdxT;

    // Opcodes 14 and 15 are left unnamed and decode as no-ops
    typedef enum logic [3:0] {
        OpAdd  = 4'd0,
        OpSub  = 4'd1,
        OpSll  = 4'd2,
        OpSrl  = 4'd3,
        OpSra  = 4'd4,
        OpNand = 4'd5,
        OpOr   = 4'd6,
        OpAddi = 4'd7,
        OpOri  = 4'd8,
        OpLw   = 4'd9,
        OpSw   = 4'd10,
        OpBeqz = 4'd11,
        OpBnez = 4'd12,
        OpJmp  = 4'd13
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd  = 3'd0,
        AluSub  = 3'd1,
        AluSll  = 3'd2,
        AluSrl  = 3'd3,
        AluSra  = 3'd4,
        AluNand = 3'd5,
        AluOr   = 3'd6
    } aluOpT;

    // First ALU operand
    typedef enum logic [1:0] {
        SrcAPc   = 2'd0,
        SrcARegB = 2'd1,
        SrcARegA = 2'd2
    } aluSrcAT;

    // Second ALU operand
    typedef enum logic [2:0] {
        SrcBRegC      = 3'd0,
        SrcBTwo       = 3'd1,
        SrcBImmByte   = 3'd2,
        SrcBBranchOff = 3'd3,
        SrcBJumpOff   = 3'd4,
        SrcBZero      = 3'd5
    } aluSrcBT;

    typedef enum logic [2:0] {
        StFetch     = 3'd0,
        StDecode    = 3'd1,
        StExecute   = 3'd2,
        StMemAccess = 3'd3,
        StWriteBack = 3'd4,
        StBranch    = 3'd5
    } cpuStateT;

endpackage
